//--- design/limn_alu.sv
`timescale 1ns/1ps

module limn_alu (
    input  limn_pkg::decoded_inst_t dec,
    input  limn_pkg::word_t         ra_data,
    input  limn_pkg::word_t         rb_data,
    output limn_pkg::word_t         result
);

    limn_pkg::word_t shifted;
    limn_pkg::word_t op_b;

    ////////////////////////////////////////////////////////////////////////////
    // Second operand
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        case (dec.shift_mode)
            limn_pkg::SH_LSR: shifted = rb_data >> dec.shamt;
            limn_pkg::SH_LSL: shifted = rb_data << dec.shamt;
            limn_pkg::SH_ASR, limn_pkg::SH_ASR_ALT: begin
                shifted = limn_pkg::word_t'($signed(rb_data) >>> dec.shamt);
            end
            default: shifted = rb_data;
        endcase
    end

    // Register form uses the shifter, everything else the immediate
    assign op_b = (dec.iclass == limn_pkg::CLS_ALU_REG) ? shifted : {16'h0, dec.imm};

    ////////////////////////////////////////////////////////////////////////////
    // Operation
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        if (dec.iclass == limn_pkg::CLS_LUI) begin
            result = ra_data | {dec.imm, 16'h0};      // Upper half merged in
        end else begin
            case (dec.alu_op)
                limn_pkg::ALU_ADD:  result = ra_data + op_b;
                limn_pkg::ALU_SUB:  result = ra_data - op_b;
                limn_pkg::ALU_AND:  result = ra_data & op_b;
                limn_pkg::ALU_XOR:  result = ra_data ^ op_b;
                limn_pkg::ALU_OR:   result = ra_data | op_b;
                limn_pkg::ALU_SLT:  result = {31'h0, ra_data < op_b};
                limn_pkg::ALU_SLTS: begin
                    result = {31'h0, $signed(ra_data) < $signed(op_b)};
                end
                limn_pkg::ALU_NOR:  result = ~(ra_data | op_b);
                default:            result = '0;
            endcase
        end
    end

endmodule

//--- design/limn_core.sv
`timescale 1ns/1ps

module limn_core #(
    parameter limn_pkg::word_t RESET_PC = limn_pkg::RESET_PC
) (
    input  logic            clk,
    input  logic            rst_n,
    output logic            imem_req,
    output limn_pkg::word_t imem_addr,
    input  logic            imem_valid,
    input  limn_pkg::word_t imem_data,
    output logic            dmem_we,
    output limn_pkg::word_t dmem_addr,
    output limn_pkg::word_t dmem_wdata
);

    limn_pkg::word_t         inst;
    limn_pkg::decoded_inst_t dec;
    limn_pkg::word_t         ra_data;
    limn_pkg::word_t         rb_data;
    limn_pkg::word_t         alu_result;
    logic                    wr_en;
    limn_pkg::reg_idx_t      wr_idx;
    limn_pkg::word_t         wr_data;

    limn_sequencer #(
        .RESET_PC   (RESET_PC)
    ) u_sequencer (
        .clk        (clk),
        .rst_n      (rst_n),
        .imem_req   (imem_req),
        .imem_addr  (imem_addr),
        .imem_valid (imem_valid),
        .imem_data  (imem_data),
        .inst       (inst),
        .dec        (dec),
        .ra_data    (ra_data),
        .rb_data    (rb_data),
        .alu_result (alu_result),
        .wr_en      (wr_en),
        .wr_idx     (wr_idx),
        .wr_data    (wr_data),
        .dmem_we    (dmem_we),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata)
    );

    limn_decoder u_decoder (
        .inst (inst),
        .dec  (dec)
    );

    // Read indices come straight from the decoded struct
    limn_regfile u_regfile (
        .clk     (clk),
        .rst_n   (rst_n),
        .ra_idx  (dec.ra),
        .rb_idx  (dec.rb),
        .ra_data (ra_data),
        .rb_data (rb_data),
        .wr_en   (wr_en),
        .wr_idx  (wr_idx),
        .wr_data (wr_data)
    );

    limn_alu u_alu (
        .dec     (dec),
        .ra_data (ra_data),
        .rb_data (rb_data),
        .result  (alu_result)
    );

endmodule

//--- design/limn_decoder.sv
`timescale 1ns/1ps

module limn_decoder (
    input  limn_pkg::word_t         inst,
    output limn_pkg::decoded_inst_t dec
);

    logic [5:0] opc;

    assign opc = inst[5:0];

    ////////////////////////////////////////////////////////////////////////////
    // Field extraction and classification
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        // Raw fields first, the class below overrides what differs
        dec.iclass     = limn_pkg::CLS_NOP;
        dec.rd         = inst[10:6];
        dec.ra         = inst[15:11];
        dec.rb         = inst[20:16];
        dec.alu_op     = limn_pkg::alu_op_e'(inst[30:28]);
        dec.shift_mode = limn_pkg::shift_mode_e'(inst[27:26]);
        dec.shamt      = inst[25:21];
        dec.link       = 1'b0;
        dec.imm        = inst[31:16];
        dec.br_off     = inst[31:11];
        dec.jidx       = inst[31:3];

        // Exact opcodes take priority over the groups
        if (opc == limn_pkg::OP_ALU_REG) begin
            dec.iclass = limn_pkg::CLS_ALU_REG;
        end else if (opc == limn_pkg::OP_BEQ) begin
            dec.iclass = limn_pkg::CLS_BEQ;
            dec.rb     = inst[10:6];              // Tested register on port B
        end else if (opc == limn_pkg::OP_BNE) begin
            dec.iclass = limn_pkg::CLS_BNE;
            dec.rb     = inst[10:6];
        end else if (opc == limn_pkg::OP_STORE) begin
            // Base on port B, data register stays on port A
            dec.iclass = limn_pkg::CLS_STORE;
            dec.rb     = inst[10:6];
        end else if (opc[2:0] == limn_pkg::OP_IMM_GRP) begin
            dec.alu_op = limn_pkg::alu_op_e'(opc[5:3]);
            if (opc[5:3] == limn_pkg::OP_LUI_HI) begin
                dec.iclass = limn_pkg::CLS_LUI;
            end else begin
                dec.iclass = limn_pkg::CLS_ALU_IMM;
            end
        end else if (opc[2:1] == limn_pkg::OP_JUMP_GRP) begin
            dec.iclass = limn_pkg::CLS_JUMP;
            dec.link   = opc[0];
            if (opc[0]) begin
                dec.rd = limn_pkg::REG_LR;        // JAL links into r31
            end
        end
        // Anything else stays a nop with no register write
    end

endmodule

//--- design/limn_pkg.sv
package limn_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Basic types
    ////////////////////////////////////////////////////////////////////////////

    typedef logic [31:0] word_t;      // Data or address word
    typedef logic [4:0]  reg_idx_t;   // Register number

    // ALU operation, same encoding in both ALU groups
    typedef enum logic [2:0] {
        ALU_NOR  = 3'b000,
        ALU_OR   = 3'b001,
        ALU_XOR  = 3'b010,
        ALU_AND  = 3'b011,
        ALU_SLTS = 3'b100,            // Signed compare
        ALU_SLT  = 3'b101,            // Unsigned compare
        ALU_SUB  = 3'b110,
        ALU_ADD  = 3'b111
    } alu_op_e;

    // Shift applied to the second operand of the register form
    typedef enum logic [1:0] {
        SH_LSR     = 2'b00,
        SH_LSL     = 2'b01,
        SH_ASR     = 2'b10,
        SH_ASR_ALT = 2'b11            // Behaves as SH_ASR
    } shift_mode_e;

    typedef enum logic [2:0] {
        CLS_NOP,
        CLS_ALU_IMM,
        CLS_LUI,
        CLS_ALU_REG,
        CLS_BEQ,
        CLS_BNE,
        CLS_JUMP,
        CLS_STORE
    } inst_class_e;

    ////////////////////////////////////////////////////////////////////////////
    // Opcodes, low six bits of the instruction
    ////////////////////////////////////////////////////////////////////////////

    // Exact matches
    localparam logic [5:0] OP_ALU_REG = 6'b111001;
    localparam logic [5:0] OP_BEQ     = 6'b111101;
    localparam logic [5:0] OP_BNE     = 6'b110101;
    localparam logic [5:0] OP_STORE   = 6'b101010;

    // Wildcard groups, compared on a slice only
    localparam logic [2:0] OP_IMM_GRP  = 3'b100;   // Bits 2:0
    localparam logic [2:0] OP_LUI_HI   = 3'b000;   // Bits 5:3 inside the imm group
    localparam logic [1:0] OP_JUMP_GRP = 2'b11;    // Bits 2:1, bit 0 selects JAL

    localparam reg_idx_t REG_LR   = 5'd31;
    localparam word_t    RESET_PC = 32'hFFFE0000;

    // Everything the datapath needs from one instruction
    typedef struct packed {
        inst_class_e iclass;
        reg_idx_t    rd;              // Write target
        reg_idx_t    ra;              // Read port A
        reg_idx_t    rb;              // Read port B
        alu_op_e     alu_op;
        shift_mode_e shift_mode;
        logic [4:0]  shamt;
        logic        link;            // JAL
        logic [15:0] imm;             // Zero-extended by its users
        logic [20:0] br_off;          // Unsigned word offset
        logic [28:0] jidx;            // Jump target word index
    } decoded_inst_t;

endpackage

//--- design/limn_regfile.sv
`timescale 1ns/1ps

module limn_regfile (
    input  logic               clk,
    input  logic               rst_n,
    input  limn_pkg::reg_idx_t ra_idx,
    input  limn_pkg::reg_idx_t rb_idx,
    output limn_pkg::word_t    ra_data,
    output limn_pkg::word_t    rb_data,
    input  logic               wr_en,
    input  limn_pkg::reg_idx_t wr_idx,
    input  limn_pkg::word_t    wr_data
);

    limn_pkg::word_t regs [32];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && (wr_idx != '0)) begin   // r0 writes dropped
            regs[wr_idx] <= wr_data;
        end
    end

    // Asynchronous reads, r0 forced to zero
    assign ra_data = (ra_idx == '0) ? '0 : regs[ra_idx];
    assign rb_data = (rb_idx == '0) ? '0 : regs[rb_idx];

endmodule

//--- design/limn_sequencer.sv
`timescale 1ns/1ps

module limn_sequencer #(
    parameter limn_pkg::word_t RESET_PC = limn_pkg::RESET_PC
) (
    input  logic                    clk,
    input  logic                    rst_n,
    output logic                    imem_req,
    output limn_pkg::word_t         imem_addr,
    input  logic                    imem_valid,
    input  limn_pkg::word_t         imem_data,
    output limn_pkg::word_t         inst,
    input  limn_pkg::decoded_inst_t dec,
    input  limn_pkg::word_t         ra_data,
    input  limn_pkg::word_t         rb_data,
    input  limn_pkg::word_t         alu_result,
    output logic                    wr_en,
    output limn_pkg::reg_idx_t      wr_idx,
    output limn_pkg::word_t         wr_data,
    output logic                    dmem_we,
    output limn_pkg::word_t         dmem_addr,
    output limn_pkg::word_t         dmem_wdata
);

    typedef enum logic [1:0] {
        S_FETCH = 2'd0,                 // Launch state after reset
        S_WAIT  = 2'd1,                 // Request outstanding
        S_EXEC  = 2'd2
    } state_e;

    state_e          state;
    limn_pkg::word_t pc;
    limn_pkg::word_t inst_q;
    logic            req_q;
    limn_pkg::word_t pc_plus4;
    limn_pkg::word_t next_pc;
    logic            taken;
    logic            writes_reg;

    ////////////////////////////////////////////////////////////////////////////
    // Next PC and writeback
    ////////////////////////////////////////////////////////////////////////////

    assign pc_plus4 = pc + 32'd4;

    always_comb begin
        taken   = 1'b0;
        next_pc = pc_plus4;
        case (dec.iclass)
            limn_pkg::CLS_BEQ:  taken = (rb_data == '0);
            limn_pkg::CLS_BNE:  taken = (rb_data != '0);
            limn_pkg::CLS_JUMP: next_pc = {pc[31], dec.jidx, 2'b00};  // Keeps the top bit
            default: ;
        endcase
        if (taken) begin
            next_pc = pc + {9'h0, dec.br_off, 2'b00};     // Forward only
        end
    end

    assign writes_reg = (dec.iclass == limn_pkg::CLS_ALU_IMM) ||
                        (dec.iclass == limn_pkg::CLS_LUI) ||
                        (dec.iclass == limn_pkg::CLS_ALU_REG) ||
                        ((dec.iclass == limn_pkg::CLS_JUMP) && dec.link);

    assign wr_en   = (state == S_EXEC) && writes_reg;
    assign wr_idx  = dec.rd;
    assign wr_data = dec.link ? pc_plus4 : alu_result;    // Link address for JAL

    // Word store, base on port B and data on port A
    assign dmem_we    = (state == S_EXEC) && (dec.iclass == limn_pkg::CLS_STORE);
    assign dmem_addr  = rb_data + {16'h0, dec.imm};
    assign dmem_wdata = ra_data;

    assign imem_req  = req_q;
    assign imem_addr = pc;
    assign inst      = inst_q;

    ////////////////////////////////////////////////////////////////////////////
    // Control FSM
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= S_FETCH;
            pc    <= RESET_PC;
            req_q <= 1'b0;
        end else begin
            req_q <= 1'b0;                              // Single-cycle strobe
            case (state)
                S_FETCH: begin
                    req_q <= 1'b1;
                    state <= S_WAIT;
                end
                S_WAIT: if (imem_valid) state <= S_EXEC;
                S_EXEC: begin
                    pc    <= next_pc;
                    req_q <= 1'b1;                      // Next fetch right away
                    state <= S_WAIT;
                end
                default: state <= S_FETCH;
            endcase
        end
    end

    // Instruction register
    always_ff @(posedge clk) begin
        if ((state == S_WAIT) && imem_valid) inst_q <= imem_data;
    end

endmodule

//--- dv/limn_core_chk.sv
`timescale 1ns/1ps

module limn_core_chk (
    input logic clk,
    input logic rst_n,
    input logic imem_req,
    input logic dmem_we
);

    logic store_seen;                   // Store done since the last request

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            store_seen <= 1'b0;
        end else if (imem_req) begin
            store_seen <= 1'b0;
        end else if (dmem_we) begin
            store_seen <= 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Strobe rules
    ////////////////////////////////////////////////////////////////////////////

    a_strobes_apart: assert property (@(posedge clk) disable iff (!rst_n)
        !(imem_req && dmem_we)) else $error("imem_req and dmem_we in the same cycle");

    a_req_single: assert property (@(posedge clk) disable iff (!rst_n)
        imem_req |=> !imem_req) else $error("imem_req high on two cycles in a row");

    a_one_store: assert property (@(posedge clk) disable iff (!rst_n)
        dmem_we |-> !store_seen) else $error("second dmem_we before the next imem_req");

    // Registers were just cleared, so both strobes must be quiet
    a_quiet_reset: assert property (@(posedge clk)
        !rst_n |=> (!imem_req && !dmem_we)) else $error("strobe high during reset");

endmodule

//--- dv/limn_core_tb.sv
`timescale 1ns/1ps

module limn_core_tb;

    localparam int          N_RANDOM = 400;          // Random instructions before the dump
    localparam int          WAIT_MAX = 20;           // Cycles allowed until a fetch shows up
    localparam logic [31:0] START_PC = 32'hFFFE0000;

    typedef struct packed {
        logic        we;
        logic [31:0] addr;
        logic [31:0] data;
    } store_t;

    logic            clk;
    logic            rst_n;
    logic            imem_req;
    limn_pkg::word_t imem_addr;
    logic            imem_valid;
    limn_pkg::word_t imem_data;
    logic            dmem_we;
    limn_pkg::word_t dmem_addr;
    limn_pkg::word_t dmem_wdata;

    integer          seed;
    int              errors;
    int              n_stores;
    logic            timed_out;
    logic [31:0]     model_regs [32];
    logic [31:0]     model_pc;
    store_t          exp_st;                          // Store the model expects next

    limn_core #(
        .RESET_PC   (START_PC)
    ) UUT (
        .clk        (clk),
        .rst_n      (rst_n),
        .imem_req   (imem_req),
        .imem_addr  (imem_addr),
        .imem_valid (imem_valid),
        .imem_data  (imem_data),
        .dmem_we    (dmem_we),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata)
    );

    bind limn_core limn_core_chk u_chk (
        .clk      (clk),
        .rst_n    (rst_n),
        .imem_req (imem_req),
        .dmem_we  (dmem_we)
    );

    always #50 clk = ~clk;

    ////////////////////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] alu_model(input logic [2:0] op, input logic [31:0] a,
                                              input logic [31:0] b);
        case (op)
            3'b111:  return a + b;
            3'b110:  return a - b;
            3'b011:  return a & b;
            3'b010:  return a ^ b;
            3'b001:  return a | b;
            3'b101:  return {31'h0, a < b};
            3'b100:  return {31'h0, $signed(a) < $signed(b)};
            default: return ~(a | b);                 // NOR
        endcase
    endfunction

    function automatic logic [31:0] shift_model(input logic [1:0] mode, input logic [4:0] amt,
                                                input logic [31:0] b);
        case (mode)
            2'b00:   return b >> amt;
            2'b01:   return b << amt;
            default: return $unsigned($signed(b) >>> amt);
        endcase
    endfunction

    task automatic model_exec(input logic [31:0] ins);
        logic [5:0]  opc;
        logic [4:0]  rd;
        logic [4:0]  ra;
        logic [4:0]  rb;
        logic [31:0] imm;
        logic [31:0] next_pc;
        opc     = ins[5:0];
        rd      = ins[10:6];
        ra      = ins[15:11];
        rb      = ins[20:16];
        imm     = {16'h0, ins[31:16]};
        next_pc = model_pc + 32'd4;
        exp_st  = '0;
        if (opc == 6'b111001) begin
            model_regs[rd] = alu_model(ins[30:28], model_regs[ra],
                                       shift_model(ins[27:26], ins[25:21], model_regs[rb]));
        end else if (opc == 6'b111101 || opc == 6'b110101) begin
            // Bit 3 set is BEQ
            if ((model_regs[rd] == 32'h0) == opc[3]) begin
                next_pc = model_pc + {9'h0, ins[31:11], 2'b00};
            end
        end else if (opc == 6'b101010) begin
            exp_st = {1'b1, model_regs[rd] + imm, model_regs[ra]};
        end else if (opc[2:0] == 3'b100) begin
            if (opc[5:3] == 3'b000) begin
                model_regs[rd] = model_regs[ra] | {ins[31:16], 16'h0};   // LUI
            end else begin
                model_regs[rd] = alu_model(opc[5:3], model_regs[ra], imm);
            end
        end else if (opc[2:1] == 2'b11) begin
            next_pc = {model_pc[31], ins[31:3], 2'b00};
            if (opc[0]) begin
                model_regs[31] = model_pc + 32'd4;
            end
        end
        model_regs[0] = 32'h0;
        model_pc      = next_pc;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus and checks
    ////////////////////////////////////////////////////////////////////////////

    task automatic make_inst(output logic [31:0] w);
        int k;
        w = $random(seed);
        k = {$random(seed)} % 16;
        case (k)
            0, 1, 2, 3: w[2:0] = 3'b100;              // Immediate group
            4:          w[5:0] = 6'b000100;           // LUI
            5, 6, 7, 8: w[5:0] = 6'b111001;
            9, 10: begin
                w[5:0]  = (k == 9) ? 6'b111101 : 6'b110101;
                w[10:8] = 3'b000;                     // Tested register r0 to r3 gives both outcomes
            end
            11:      w[2:1] = 2'b11;                  // J or JAL
            12, 13:  w[5:0] = 6'b101010;
            default: w[2:0] = 3'b000;                 // Unknown opcode
        endcase
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] want);
        errors++;
        $display("[FAIL] t=%0t %s: got %h, expected %h", $time, name, got, want);
    endtask

    // One cycle with no store allowed
    task automatic idle_cycle();
        @(negedge clk);
        if (dmem_we !== 1'b0) begin
            report_mismatch("dmem_we", {31'h0, dmem_we}, 32'h0);
        end
    endtask

    task automatic wait_for_req();
        int n;
        for (n = 0; n < WAIT_MAX; n++) begin
            idle_cycle();
            if (imem_req) break;
        end
        if (n == WAIT_MAX) begin
            errors++;
            timed_out = 1'b1;
            $display("ERROR at %0t: no imem_req within %0d cycles", $time, WAIT_MAX);
        end
    endtask

    task automatic check_store();
        if (dmem_we !== exp_st.we) begin
            report_mismatch("dmem_we", {31'h0, dmem_we}, {31'h0, exp_st.we});
        end else if (exp_st.we) begin
            n_stores++;
            if (dmem_addr !== exp_st.addr) report_mismatch("dmem_addr", dmem_addr, exp_st.addr);
            if (dmem_wdata !== exp_st.data) report_mismatch("dmem_wdata", dmem_wdata, exp_st.data);
        end
    endtask

    initial begin
        logic [31:0] ins;
        int          delay;
        int          i;
        clk        = 1'b0;
        rst_n      = 1'b0;
        imem_valid = 1'b0;
        imem_data  = '0;
        seed       = 32'h5ad3a3c3;
        errors     = 0;
        n_stores   = 0;
        timed_out  = 1'b0;
        model_pc   = START_PC;
        for (i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end

        repeat (5) @(negedge clk);
        rst_n = 1'b1;

        for (i = 0; (i < N_RANDOM + 31) && !timed_out; i++) begin
            wait_for_req();
            if (!timed_out) begin
                if (imem_addr !== model_pc) report_mismatch("imem_addr", imem_addr, model_pc);
                if (i < N_RANDOM) begin
                    make_inst(ins);
                end else begin
                    ins = {16'h0, 5'(i - N_RANDOM + 1), 5'd0, 6'b101010};   // Dump to address 0
                end
                model_exec(ins);
                delay = 1 + int'({$random(seed)} % 4);
                repeat (delay) idle_cycle();
                imem_valid = 1'b1;
                imem_data  = ins;
                @(negedge clk);                        // Execute cycle
                imem_valid = 1'b0;
                imem_data  = $random(seed);
                check_store();
            end
        end

        $display("Run finished: %0d instructions, %0d stores checked, %0d errors",
                 i, n_stores, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

//--- limn_core.f
design/limn_pkg.sv
design/limn_decoder.sv
design/limn_regfile.sv
design/limn_alu.sv
design/limn_sequencer.sv
design/limn_core.sv
dv/limn_core_chk.sv
dv/limn_core_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Builds the limn_core testbench with Verilator and runs it
set -e
set -o pipefail

cd "$(dirname "$0")"

BUILD_DIR=obj_dir
LOG=sim.log

rm -rf "$BUILD_DIR" "$LOG"

verilator --binary --timing --assert -j 0 \
    --top-module limn_core_tb \
    --Mdir "$BUILD_DIR" -o limn_core_sim \
    -f limn_core.f

"./$BUILD_DIR/limn_core_sim" | tee "$LOG"

if grep -qF "** FAIL **" "$LOG"; then
    echo "Simulation reported failure"
    exit 1
fi
echo "Simulation finished without failure"
